//--- hdl/button_sync.sv
module button_sync (
   input logic clk,
   input logic rst_n,
   input game_pkg::led_t buttons,
   input logic start,
   output game_pkg::led_t press,
   output logic any_press,
   output logic start_pulse
);
   import game_pkg::*;

   // bit 4 is start, bits 3:0 the colour buttons
   logic [4:0] pins;
   logic [4:0] sync1;
   logic [4:0] sync2;
   logic [4:0] hist;
   logic [4:0] rise;
   led_t btn_rise;
   led_t first;

   assign pins = {start, buttons};

   // rising edge on the synchronised level
   assign rise = sync2 & ~hist;
   assign btn_rise = rise[3:0];

   // keep the lowest set bit when buttons rise together
   assign first = btn_rise & (~btn_rise + led_t'(1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync1 <= '0;
         sync2 <= '0;
         hist <= '0;
         press <= '0;
         any_press <= 1'b0;
         start_pulse <= 1'b0;
      end else begin
         // two flops against metastability, third one remembers the level
         sync1 <= pins;
         sync2 <= sync1;
         hist <= sync2;
         // registered one-cycle pulses
         press <= first;
         any_press <= |btn_rise;
         start_pulse <= rise[4];
      end
   end

endmodule

//--- hdl/game_fsm.sv
module game_fsm (
   input logic clk,
   input logic rst_n,
   input game_pkg::led_t press,
   input logic start_pulse,
   input game_pkg::color_t rnd,
   seq_if.ctrl bus,
   output game_pkg::led_t led,
   output logic listening,
   output logic win,
   output logic fail,
   output game_pkg::len_t round
);
   import game_pkg::*;

   game_state_t state;
   game_state_t state_d;
   idx_t idx;
   idx_t idx_d;
   // counts show and gap cycles, 6 fits in 3 bits
   logic [2:0] cyc;
   logic [2:0] cyc_d;
   led_t expect_led;
   logic last_entry;

   // colour at the current index as a lamp vector
   assign expect_led = led_t'(1) << bus.rd_color;

   // current index is the final entry of the stored sequence
   assign last_entry = (len_t'(idx) + len_t'(1) == bus.length);

   assign bus.rd_idx = idx;
   assign bus.wr_color = rnd;

   always_comb begin
      state_d = state;
      idx_d = idx;
      cyc_d = cyc;
      bus.clear = 1'b0;
      bus.append = 1'b0;

      case (state)
         IDLE: begin
            // only start leaves idle
         end
         APPEND: begin
            // one new colour per round, playback from the top
            bus.append = 1'b1;
            idx_d = '0;
            cyc_d = '0;
            state_d = SHOW;
         end
         SHOW: begin
            if (cyc == 3'(SHOW_CYCLES - 1)) begin
               cyc_d = '0;
               state_d = GAP;
            end else begin
               cyc_d = cyc + 3'd1;
            end
         end
         GAP: begin
            if (cyc == 3'(GAP_CYCLES - 1)) begin
               cyc_d = '0;
               if (last_entry) begin
                  idx_d = '0;
                  state_d = LISTEN;
               end else begin
                  idx_d = idx + idx_t'(1);
                  state_d = SHOW;
               end
            end else begin
               cyc_d = cyc + 3'd1;
            end
         end
         LISTEN: begin
            // compare each press against the stored colour in the same cycle
            if (press != '0) begin
               if (press != expect_led) begin
                  state_d = FAIL;
               end else if (!last_entry) begin
                  idx_d = idx + idx_t'(1);
               end else if (bus.length == MAX_LEN) begin
                  state_d = WIN;
               end else begin
                  state_d = APPEND;
               end
            end
         end
         WIN, FAIL: begin
            // hold until the next start
         end
         default: begin
            state_d = IDLE;
         end
      endcase

      // start restarts the game from any state
      if (start_pulse) begin
         bus.clear = 1'b1;
         bus.append = 1'b0;
         idx_d = '0;
         cyc_d = '0;
         state_d = APPEND;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         idx <= '0;
         cyc <= '0;
      end else begin
         state <= state_d;
         idx <= idx_d;
         cyc <= cyc_d;
      end
   end

   // lamp lit only while a colour is shown, dark in the gaps
   assign led = (state == SHOW) ? expect_led : '0;
   assign listening = (state == LISTEN);
   assign win = (state == WIN);
   assign fail = (state == FAIL);

   // round number is the stored sequence length
   assign round = bus.length;

endmodule

//--- hdl/game_pkg.sv
package game_pkg;

   // colour index, 0 to 3
   typedef logic [1:0] color_t;

   // one-hot vector, one bit per lamp or button
   typedef logic [3:0] led_t;

   // position inside the stored sequence
   typedef logic [2:0] idx_t;

   // number of stored colours, 0 to 8
   typedef logic [3:0] len_t;

   // sequence length that wins the game
   localparam len_t MAX_LEN = 4'd8;

   // playback timing in clock cycles
   localparam int unsigned SHOW_CYCLES = 6;
   localparam int unsigned GAP_CYCLES = 2;

   // controller states
   typedef enum logic [2:0] {
      IDLE,
      APPEND,
      SHOW,
      GAP,
      LISTEN,
      WIN,
      FAIL
   } game_state_t;

endpackage

//--- hdl/random_generator.sv
module random_generator (
   input logic clk,
   input logic rst_n,
   input rng_pkg::div_cnt_t mcnt1,
   input rng_pkg::div_cnt_t mcnt2,
   input logic button_pressed,
   output game_pkg::color_t rnd
);
   import rng_pkg::*;

   logic tick1;
   logic tick2;
   lfsr_t lfsr1;
   lfsr_t lfsr2;

   // one LFSR step, feedback from both taps into bit 0
   function automatic lfsr_t lfsr_step(input lfsr_t s);
      return {s[0], s[1] ^ s[0]};
   endfunction

   // each press restarts both dividers, so player timing sets the phase
   tick_divider div1_inst (
      .clk(clk),
      .rst_n(rst_n),
      .restart(button_pressed),
      .mcnt(mcnt1),
      .tick(tick1)
   );

   tick_divider div2_inst (
      .clk(clk),
      .rst_n(rst_n),
      .restart(button_pressed),
      .mcnt(mcnt2),
      .tick(tick2)
   );

   // first LFSR, steps at the mcnt1 rate
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr1 <= LFSR1_SEED;
      end else if (tick1) begin
         lfsr1 <= lfsr_step(lfsr1);
      end
   end

   // second LFSR, steps at the mcnt2 rate
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr2 <= LFSR2_SEED;
      end else if (tick2) begin
         lfsr2 <= lfsr_step(lfsr2);
      end
   end

   // mixing two rates gives all four colours, zero included
   assign rnd = game_pkg::color_t'(lfsr1 ^ lfsr2);

endmodule

//--- hdl/rng_pkg.sv
package rng_pkg;

   // period of one tick divider, set from the mcnt pins
   typedef logic [3:0] div_cnt_t;

   // running cycle count inside a divider
   typedef logic [13:0] div_acc_t;

   // state of one 2-bit LFSR, polynomial x^2 + x + 1
   typedef logic [1:0] lfsr_t;

   // seeds must be non-zero or the LFSR locks up
   localparam lfsr_t LFSR1_SEED = 2'b11;
   localparam lfsr_t LFSR2_SEED = 2'b10;

endpackage

//--- hdl/seq_if.sv
interface seq_if;
   import game_pkg::*;

   // controller to memory
   logic clear;
   logic append;
   color_t wr_color;
   idx_t rd_idx;

   // memory to controller, rd_color is a combinational read
   color_t rd_color;
   len_t length;

   modport ctrl (
      output clear,
      output append,
      output wr_color,
      output rd_idx,
      input rd_color,
      input length
   );

   modport mem (
      input clear,
      input append,
      input wr_color,
      input rd_idx,
      output rd_color,
      output length
   );

endinterface

//--- hdl/sequence_store.sv
module sequence_store (
   input logic clk,
   input logic rst_n,
   seq_if.mem bus
);
   import game_pkg::*;

   color_t mem [0:MAX_LEN-1];
   len_t len_q;
   logic full;
   logic wr_en;

   assign full = (len_q == MAX_LEN);

   // clear wins, and a full memory ignores further appends
   assign wr_en = bus.append && !bus.clear && !full;

   // length counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         len_q <= '0;
      end else if (bus.clear) begin
         len_q <= '0;
      end else if (wr_en) begin
         len_q <= len_q + len_t'(1);
      end
   end

   // colour storage, write at the current end of the sequence
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[idx_t'(len_q)] <= bus.wr_color;
      end
   end

   // combinational read for playback and checking
   assign bus.rd_color = mem[bus.rd_idx];
   assign bus.length = len_q;

endmodule

//--- hdl/simon_top.sv
module simon_top (
   input logic clk,
   input logic rst_n,
   input game_pkg::led_t buttons,
   input logic start,
   input rng_pkg::div_cnt_t mcnt1,
   input rng_pkg::div_cnt_t mcnt2,
   output game_pkg::led_t led,
   output logic listening,
   output logic win,
   output logic fail,
   output game_pkg::len_t round
);
   import game_pkg::*;

   led_t press;
   logic any_press;
   logic start_pulse;
   color_t rnd;

   // controller to sequence memory
   seq_if seq_bus ();

   // pins to clean one-cycle pulses
   button_sync sync_inst (
      .clk(clk),
      .rst_n(rst_n),
      .buttons(buttons),
      .start(start),
      .press(press),
      .any_press(any_press),
      .start_pulse(start_pulse)
   );

   // every player press reshuffles the random source
   random_generator rng_inst (
      .clk(clk),
      .rst_n(rst_n),
      .mcnt1(mcnt1),
      .mcnt2(mcnt2),
      .button_pressed(any_press),
      .rnd(rnd)
   );

   sequence_store store_inst (
      .clk(clk),
      .rst_n(rst_n),
      .bus(seq_bus.mem)
   );

   game_fsm fsm_inst (
      .clk(clk),
      .rst_n(rst_n),
      .press(press),
      .start_pulse(start_pulse),
      .rnd(rnd),
      .bus(seq_bus.ctrl),
      .led(led),
      .listening(listening),
      .win(win),
      .fail(fail),
      .round(round)
   );

endmodule

//--- hdl/tick_divider.sv
module tick_divider (
   input logic clk,
   input logic rst_n,
   input logic restart,
   input rng_pkg::div_cnt_t mcnt,
   output logic tick
);
   import rng_pkg::*;

   div_acc_t cnt;
   div_acc_t last;
   logic wrap;

   // terminal count, a period of 0 behaves like 1
   always_comb begin
      if (mcnt == '0) begin
         last = '0;
      end else begin
         last = div_acc_t'(mcnt) - div_acc_t'(1);
      end
   end

   assign wrap = (cnt == last);

   // restart wins over the tick, so a press never yields a tick that cycle
   assign tick = wrap && !restart;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (restart) begin
         cnt <= '0;
      end else if (wrap) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + div_acc_t'(1);
      end
   end

endmodule

//--- test/simon_checker.sv
module simon_checker (
   input logic clk,
   input logic rst_n,
   input game_pkg::led_t led,
   input logic listening,
   input logic win,
   input logic fail,
   input game_pkg::len_t round
);
   import game_pkg::*;

   // running count of assertion failures, summed into the final result
   int assert_fails = 0;

   // at most one lamp lit at any time
   led_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(led))
      else begin
         $error("more than one lamp lit at once");
         assert_fails++;
      end

   // the game cannot be won and lost together
   win_fail_excl: assert property (@(posedge clk) disable iff (!rst_n) !(win && fail))
      else begin
         $error("win and fail are high together");
         assert_fails++;
      end

   // lamps stay dark while the player answers
   listen_dark: assert property (@(posedge clk) disable iff (!rst_n) listening |-> led == '0)
      else begin
         $error("a lamp is lit while listening");
         assert_fails++;
      end

   // sequence never grows past the winning length
   round_limit: assert property (@(posedge clk) disable iff (!rst_n) round <= MAX_LEN)
      else begin
         $error("round counter went past the maximum sequence length");
         assert_fails++;
      end

endmodule

bind simon_top simon_checker checker_inst (
   .clk(clk),
   .rst_n(rst_n),
   .led(led),
   .listening(listening),
   .win(win),
   .fail(fail),
   .round(round)
);

//--- test/simon_tb.sv
module simon_tb;
   import game_pkg::*;
   import rng_pkg::*;

   localparam int NUM_TESTS = 5;
   // entries x rounds x (playback + slack) x clock period
   localparam int WATCHDOG_TIME = NUM_TESTS * int'(MAX_LEN) * (int'(MAX_LEN) * 8 + 100) * 8;

   logic clk;
   logic rst_n;
   led_t buttons;
   logic start;
   div_cnt_t mcnt1;
   div_cnt_t mcnt2;
   led_t led;
   logic listening;
   logic win;
   logic fail;
   len_t round;

   // name, divider periods, round and position of the wrong press (round 0 = none)
   string test_names [NUM_TESTS] = '{"win_a", "fail_r3", "fail_r1", "win_rand", "fail_r8"};
   int mcnt1_tab [NUM_TESTS] = '{3, 2, 0, 0, 6};
   int mcnt2_tab [NUM_TESTS] = '{5, 7, 4, 0, 9};
   int err_round_tab [NUM_TESTS] = '{0, 3, 1, 0, 8};
   int err_pos_tab [NUM_TESTS] = '{0, 1, 0, 0, 7};
   // divider periods come from the LFSR instead of the table
   bit rand_rate_tab [NUM_TESTS] = '{0, 0, 0, 1, 0};

   logic [15:0] lfsr_state;
   string test_name;
   int checks;
   int errors;
   color_t prev_seq [$];
   color_t shown [$];

   simon_top simon_top_inst (
      .clk(clk),
      .rst_n(rst_n),
      .buttons(buttons),
      .start(start),
      .mcnt1(mcnt1),
      .mcnt2(mcnt2),
      .led(led),
      .listening(listening),
      .win(win),
      .fail(fail),
      .round(round)
   );

   always #4 clk = ~clk;

   // galois LFSR, taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   // one LFSR step per bit taken
   task automatic rand_bits(input int n, output int v);
      v = 0;
      repeat (n) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
   endtask

   // lit lamp back to its colour index
   function automatic color_t lamp_color(input led_t l);
      case (l)
         4'b0010: return color_t'(1);
         4'b0100: return color_t'(2);
         4'b1000: return color_t'(3);
         default: return color_t'(0);
      endcase
   endfunction

   // inputs change just after the rising edge, outputs are settled there
   task automatic step;
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string what, input int exp, input int got);
      checks++;
      assert (got == exp) else begin
         $display("[FAIL] %s %s expected %0d actual %0d", test_name, what, exp, got);
         errors++;
      end
   endtask

   // hold a button 2 cycles, then release it
   task automatic press_color(input color_t c);
      buttons = led_t'(1) << c;
      step;
      step;
      buttons = '0;
   endtask

   // random 2 to 9 cycle pause between presses
   task automatic random_gap;
      int gap;
      rand_bits(3, gap);
      repeat (gap + 2) step;
   endtask

   // record playback until listening, with one stray press while a lamp is lit
   task automatic play_round(input int r);
      led_t prev_led;
      int hold;
      int stray;
      bit stray_done;
      prev_led = '0;
      hold = 0;
      stray_done = 0;
      shown.delete();
      while (listening) step;
      while (!listening) begin
         step;
         if (hold > 0) begin
            hold--;
            if (hold == 0) begin
               buttons = '0;
            end
         end
         // new colour on each dark to lit change
         if (led != '0 && prev_led == '0) begin
            shown.push_back(lamp_color(led));
            if (!stray_done) begin
               rand_bits(2, stray);
               buttons = led_t'(1) << stray;
               hold = 2;
               stray_done = 1;
            end
         end
         prev_led = led;
      end
      check_value("shown length", r, shown.size());
      check_value("round", r, int'(round));
      check_value("win during play", 0, int'(win));
      check_value("fail during play", 0, int'(fail));
      // earlier colours repeat in the same order
      for (int i = 0; i < prev_seq.size() && i < shown.size(); i++) begin
         check_value($sformatf("colour %0d", i), int'(prev_seq[i]), int'(shown[i]));
      end
      prev_seq = shown;
   endtask

   // wait for win or fail, bounded
   task automatic wait_end(output bit ok);
      ok = 0;
      repeat (40) begin
         if (!ok && (win || fail)) begin
            ok = 1;
         end
         if (!ok) begin
            step;
         end
      end
   endtask

   task automatic run_test(input int t);
      int v;
      int wrong;
      bit ok;
      color_t c;
      test_name = test_names[t];
      prev_seq.delete();
      if (rand_rate_tab[t]) begin
         rand_bits(4, v);
         mcnt1 = div_cnt_t'(v);
         rand_bits(4, v);
         mcnt2 = div_cnt_t'(v);
      end else begin
         mcnt1 = div_cnt_t'(mcnt1_tab[t]);
         mcnt2 = div_cnt_t'(mcnt2_tab[t]);
      end
      start = 1'b1;
      step;
      step;
      start = 1'b0;
      for (int r = 1; r <= int'(MAX_LEN); r++) begin
         play_round(r);
         for (int i = 0; i < r; i++) begin
            c = shown[i];
            if (i > 0) begin
               random_gap;
            end
            if (r == err_round_tab[t] && i == err_pos_tab[t]) begin
               // correct colour xor a non-zero value
               wrong = 0;
               while (wrong == 0) begin
                  rand_bits(2, wrong);
               end
               press_color(c ^ color_t'(wrong));
               wait_end(ok);
               if (!ok) begin
                  $display("%s: the game did not fail after a wrong press", test_name);
                  errors++;
               end
               check_value("fail", 1, int'(fail));
               check_value("win after error", 0, int'(win));
               check_value("round after error", r, int'(round));
               check_value("listening after error", 0, int'(listening));
               // presses after a failure change nothing
               random_gap;
               press_color(c);
               random_gap;
               check_value("fail held", 1, int'(fail));
               check_value("round held", r, int'(round));
               check_value("listening held", 0, int'(listening));
               return;
            end
            press_color(c);
         end
      end
      wait_end(ok);
      if (!ok) begin
         $display("%s: no win after eight correct rounds", test_name);
         errors++;
      end
      check_value("win", 1, int'(win));
      check_value("fail at win", 0, int'(fail));
      check_value("round at win", int'(MAX_LEN), int'(round));
      check_value("listening at win", 0, int'(listening));
   endtask

   initial begin
      int assert_total;
      clk = 1'b0;
      rst_n = 1'b0;
      buttons = '0;
      start = 1'b0;
      mcnt1 = '0;
      mcnt2 = '0;
      lfsr_state = 16'd77;
      checks = 0;
      errors = 0;
      test_name = "reset";
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      step;
      check_value("led", 0, int'(led));
      check_value("win", 0, int'(win));
      check_value("fail", 0, int'(fail));
      check_value("listening", 0, int'(listening));
      check_value("round", 0, int'(round));
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      assert_total = simon_top_inst.checker_inst.assert_fails;
      $display("checks %0d, value errors %0d, assertion failures %0d",
               checks, errors, assert_total);
      if (errors == 0 && assert_total == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // watchdog against a stuck game
   initial begin
      #(WATCHDOG_TIME);
      $display("timeout, the tests did not finish within %0d time units", WATCHDOG_TIME);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- verilog.f
hdl/rng_pkg.sv
hdl/game_pkg.sv
hdl/seq_if.sv
hdl/tick_divider.sv
hdl/random_generator.sv
hdl/button_sync.sv
hdl/sequence_store.sv
hdl/game_fsm.sv
hdl/simon_top.sv
test/simon_checker.sv
test/simon_tb.sv
